// ==== voice_recorder.f ====
+incdir+bench
rtl/voice_recorder_pkg.sv
rtl/button_debouncer.sv
rtl/volume_control.sv
rtl/codec_control.sv
rtl/sample_ram.sv
rtl/recorder.sv
rtl/voice_recorder_top.sv
bench/voice_recorder_tb.sv

// ==== bench/voice_recorder_model.svh ====
`ifndef VOICE_RECORDER_MODEL_SVH
`define VOICE_RECORDER_MODEL_SVH

////////////////////////////////////////////////////////////
// reference model of the recorder and the codec commands
////////////////////////////////////////////////////////////

// half plus quarter of the current sample, plus a quarter of the echo
function automatic sample_t mix_sample(input sample_t current, input sample_t echo);
  int sum;
  sum = (int'(current) >> 1) + (int'(current) >> 2) + (int'(echo) >> 2);
  return sample_t'(sum);
endfunction

// echo tap sits ECHO_DELAY behind, or on the sample itself near the start
function automatic int echo_address(input int addr);
  if (addr > ECHO_DELAY)
    return addr - ECHO_DELAY;
  return addr;
endfunction

function automatic volume_t attenuation(input volume_t vol);
  return volume_t'(VOLUME_MAX - vol);
endfunction

function automatic codec_command_t expected_command(input int step, input volume_t vol);
  codec_command_t cmd;
  cmd.valid = 1'b1;
  cmd.address = REG_READ_ID;
  cmd.data = 16'h0000;
  case (step)
    3:
    begin
      cmd.address = REG_HEADPHONE_VOL;
      // left channel in the high byte, right in the low byte
      cmd.data[12:8] = attenuation(vol);
      cmd.data[4:0] = attenuation(vol);
    end
    5:
    begin
      cmd.address = REG_PCM_VOL;
      cmd.data = PCM_VOL_DATA;
    end
    6:
    begin
      cmd.address = REG_RECORD_SELECT;
      cmd.data[10:8] = MIC_SOURCE;
      cmd.data[2:0] = MIC_SOURCE;
    end
    7:
    begin
      cmd.address = REG_RECORD_GAIN;
      cmd.data = RECORD_GAIN_DATA;
    end
    9:
    begin
      cmd.address = REG_MIC_GAIN;
      cmd.data = MIC_GAIN_DATA;
    end
    10:
    begin
      cmd.address = REG_BEEP_VOL;
      cmd.data = BEEP_VOL_DATA;
    end
    11:
    begin
      cmd.address = REG_GENERAL;
      cmd.data = BYPASS_DATA;
    end
    default:
    begin
      cmd.address = REG_READ_ID;
    end
  endcase
  return cmd;
endfunction

`endif

// ==== bench/voice_recorder_tb.sv ====
`timescale 1ns/1ps

module voice_recorder_tb
  import voice_recorder_pkg::*;
();

  // about twice the cycles that the whole sequence needs
  localparam int TIMEOUT_CYCLES = 150000;
  localparam int PRESS_HOLD = DEBOUNCE_CYCLES + 6;
  // edges from driving a press to the volume step that it causes
  localparam int STEP_DELAY = DEBOUNCE_CYCLES + 3;
  localparam int FIRST_LENGTH = 300;
  localparam int SECOND_LENGTH = 150;

  logic           clock;
  logic           reset;
  logic           sample_strobe;
  sample_t        mic_sample;
  buttons_t       buttons;
  sample_t        audio_out;
  volume_t        volume;
  logic           codec_reset_b;
  codec_command_t command;

  // bench copy of the recorder state
  sample_t stored [0:(1 << ADDR_WIDTH)-1];
  sample_t audio_queue [$];
  logic strobes_on;
  logic [2:0] strobe_phase;
  logic model_playback;
  int model_addr;
  int model_decim;
  int model_length;
  sample_t model_last;
  int strobe_count;
  int step_model;
  volume_t volume_model;
  int cycle_count;
  integer seed;

  `include "voice_recorder_model.svh"

  voice_recorder_top i_dut (
    .clock         (clock),
    .reset         (reset),
    .sample_strobe (sample_strobe),
    .mic_sample    (mic_sample),
    .buttons       (buttons),
    .audio_out     (audio_out),
    .volume        (volume),
    .codec_reset_b (codec_reset_b),
    .command       (command)
  );

  initial
  begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  ////////////////////////////////////////////////////////////
  // checking helpers
  ////////////////////////////////////////////////////////////

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string what);
    if (actual !== expected)
    begin
      $display("Mismatch at %0t: %s, got 0x%0h, expected 0x%0h",
               $time, what, actual, expected);
      $display("Verification failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic abort_run(input string reason);
    $display("Error at %0t: %s", $time, reason);
    $display("Verification failed");
    $fatal(1, reason);
  endtask

  initial
  begin : watchdog
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES)
    begin
      @(posedge clock);
      cycle_count = cycle_count + 1;
    end
    abort_run("timeout, the test sequence did not finish within the cycle limit");
  end

  ////////////////////////////////////////////////////////////
  // strobe driver with one strobe every 8 cycles while enabled
  ////////////////////////////////////////////////////////////

  always @(posedge clock)
  begin : strobe_driver
    sample_t value;
    if (reset || !strobes_on)
    begin
      sample_strobe <= 1'b0;
      strobe_phase <= '0;
    end
    else if (strobe_phase != '0)
    begin
      sample_strobe <= 1'b0;
      strobe_phase <= strobe_phase + 1'b1;
    end
    else
    begin
      value = sample_t'($random(seed));
      sample_strobe <= 1'b1;
      mic_sample <= value;
      strobe_phase <= strobe_phase + 1'b1;
      strobe_count = strobe_count + 1;
      if (!model_playback)
      begin
        // first strobe of each group is kept until memory is full
        if (model_decim == 0 && model_addr < (1 << ADDR_WIDTH) - 1)
        begin
          stored[model_addr] = value;
          model_last = value;
          model_addr = model_addr + 1;
        end
        audio_queue.push_back(model_last);
      end
      else
      begin
        audio_queue.push_back(mix_sample(stored[model_addr],
                                         stored[echo_address(model_addr)]));
        if (model_decim == DECIMATION - 1)
        begin
          model_addr = model_addr + 1;
          if (model_addr >= model_length)
            model_addr = 0;
        end
      end
      model_decim = (model_decim + 1) % DECIMATION;
    end
  end

  // command one cycle and audio_out three cycles after each strobe
  initial
  begin : compare_process
    volume_t volume_seen;
    codec_command_t expected;
    forever
    begin
      @(negedge clock);
      if (!reset && sample_strobe)
      begin
        if (codec_reset_b)
          step_model = (step_model + 1) % SEQUENCE_LENGTH;
        @(negedge clock);
        // value the codec block uses when it registers the command
        volume_seen = volume_model;
        @(negedge clock);
        expected = expected_command(step_model, volume_seen);
        check(command, expected, $sformatf("command at step %0d", step_model));
        @(negedge clock);
        check(audio_out, audio_queue.pop_front(), "audio_out after strobe");
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////////////////////////

  // a press held for STEP_DELAY edges moves the expected volume on that edge
  task automatic press_button(input logic is_up, input int hold);
    @(posedge clock);
    if (is_up)
      buttons.up <= 1'b1;
    else
      buttons.down <= 1'b1;
    for (int i = 0; i < hold; i++)
    begin
      @(posedge clock);
      if (i == STEP_DELAY - 1)
      begin
        if (is_up && volume_model != VOLUME_MAX)
          volume_model = volume_model + 1'b1;
        else if (!is_up && volume_model != '0)
          volume_model = volume_model - 1'b1;
      end
    end
    buttons.up <= 1'b0;
    buttons.down <= 1'b0;
    repeat (PRESS_HOLD) @(posedge clock);
    @(negedge clock);
  endtask

  task automatic step_volume(input logic is_up);
    press_button(is_up, PRESS_HOLD);
    check(volume, volume_model, is_up ? "volume after up press" : "volume after down press");
  endtask

  // strobes pause while the playback button settles
  task automatic switch_mode(input logic to_playback);
    strobes_on = 1'b0;
    while (audio_queue.size() != 0)
      @(negedge clock);
    @(posedge clock);
    buttons.playback <= to_playback;
    repeat (PRESS_HOLD) @(negedge clock);
    if (to_playback)
      model_length = model_addr;
    model_addr = 0;
    model_decim = 0;
    model_playback = to_playback;
    strobes_on = 1'b1;
  endtask

  task automatic wait_for_stores(input int count);
    while (model_addr < count)
      @(negedge clock);
  endtask

  task automatic play_strobes(input int count);
    int target;
    target = strobe_count + count;
    while (strobe_count < target)
      @(negedge clock);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial
  begin : main_sequence
    int release_cycles;
    seed = 32'h22d6;
    reset = 1'b1;
    sample_strobe = 1'b0;
    mic_sample = '0;
    buttons = '0;
    strobes_on = 1'b0;
    model_playback = 1'b0;
    model_addr = 0;
    model_decim = 0;
    model_length = 0;
    model_last = '0;
    strobe_count = 0;
    step_model = 0;
    volume_model = VOLUME_RESET;

    repeat (3) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    check(volume, VOLUME_RESET, "volume after reset");
    check(codec_reset_b, 1'b0, "codec_reset_b after reset");
    check(command.valid, 1'b0, "command.valid after reset");
    check(audio_out, 8'h00, "audio_out after reset");

    // codec stays in reset for a fixed count
    release_cycles = 0;
    while (!codec_reset_b)
    begin
      check(command.valid, 1'b0, "command.valid before codec release");
      release_cycles = release_cycles + 1;
      @(negedge clock);
    end
    check(release_cycles, CODEC_RESET_CYCLES, "cycles until codec release");

    // recording runs in the background from here
    strobes_on = 1'b1;
    step_volume(1'b1);
    step_volume(1'b0);
    press_button(1'b1, DEBOUNCE_CYCLES / 2);
    check(volume, volume_model, "volume after short press");
    repeat (30) step_volume(1'b1);
    check(volume, VOLUME_MAX, "volume saturates at the top");
    repeat (40) step_volume(1'b0);
    check(volume, 5'd0, "volume saturates at zero");
    repeat (5) step_volume(1'b1);

    wait_for_stores(FIRST_LENGTH);
    switch_mode(1'b1);
    play_strobes(FIRST_LENGTH * DECIMATION + 400);

    // record a shorter take over the start of the memory
    switch_mode(1'b0);
    wait_for_stores(SECOND_LENGTH);
    switch_mode(1'b1);
    play_strobes(2 * SECOND_LENGTH * DECIMATION);

    strobes_on = 1'b0;
    while (audio_queue.size() != 0)
      @(negedge clock);
    repeat (4) @(negedge clock);

    $display("Verification passed");
    $finish;
  end

endmodule

// ==== rtl/voice_recorder_top.sv ====
`timescale 1ns/1ps

module voice_recorder_top
  import voice_recorder_pkg::*;
(
  input  logic           clock,
  input  logic           reset,
  input  logic           sample_strobe,
  input  sample_t        mic_sample,
  input  buttons_t       buttons,
  output sample_t        audio_out,
  output volume_t        volume,
  output logic           codec_reset_b,
  output codec_command_t command
);

  // debounced level that is high for playback and low for record
  logic playback;

  button_debouncer i_playback_debouncer (
    .clock (clock),
    .reset (reset),
    .noisy (buttons.playback),
    .clean (playback)
  );

  volume_control i_volume_control (
    .clock  (clock),
    .reset  (reset),
    .up     (buttons.up),
    .down   (buttons.down),
    .volume (volume)
  );

  codec_control i_codec_control (
    .clock         (clock),
    .reset         (reset),
    .sample_strobe (sample_strobe),
    .volume        (volume),
    .codec_reset_b (codec_reset_b),
    .command       (command)
  );

  recorder i_recorder (
    .clock         (clock),
    .reset         (reset),
    .sample_strobe (sample_strobe),
    .mic_sample    (mic_sample),
    .playback      (playback),
    .audio_out     (audio_out)
  );

endmodule

// ==== rtl/recorder.sv ====
`timescale 1ns/1ps

module recorder
  import voice_recorder_pkg::*;
(
  input  logic    clock,
  input  logic    reset,
  input  logic    sample_strobe,
  input  sample_t mic_sample,
  input  logic    playback,
  output sample_t audio_out
);

  logic playback_q;
  logic mode_change;
  logic [$clog2(DECIMATION)-1:0] decim_count;
  logic decim_last;
  addr_t addr;
  addr_t next_addr;
  addr_t echo_addr;
  addr_t record_length;
  logic full;
  logic write_enable;
  sample_t last_stored;
  sample_t read_data;
  sample_t echo_data;
  sample_t mix;
  sample_t out_stage;
  logic strobe_d1;
  logic strobe_d2;

  sample_ram i_sample_ram (
    .clock        (clock),
    .write_enable (write_enable),
    .write_addr   (addr),
    .write_data   (mic_sample),
    .read_addr    (addr),
    .echo_addr    (echo_addr),
    .read_data    (read_data),
    .echo_data    (echo_data)
  );

  ////////////////////////////////////////////////////////////
  // addressing
  ////////////////////////////////////////////////////////////

  assign mode_change = playback ^ playback_q;
  assign decim_last = (decim_count == DECIMATION - 1);
  assign next_addr = addr + 1'b1;
  // last location stays free so the length fits in addr_t
  assign full = (addr == '1);

  // store on the first strobe of every decimation group
  assign write_enable = sample_strobe && !playback_q && !mode_change &&
                        decim_count == '0 && !full;

  // echo tap stays on the current sample near the start
  assign echo_addr = (addr > addr_t'(ECHO_DELAY)) ? addr - addr_t'(ECHO_DELAY) : addr;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      playback_q <= 1'b0;
      decim_count <= '0;
      addr <= '0;
      record_length <= '0;
    end
    else
    begin
      playback_q <= playback;
      if (mode_change)
      begin
        decim_count <= '0;
        addr <= '0;
        // on entry to playback the address equals the number of stored samples
        if (playback)
          record_length <= addr;
      end
      else if (sample_strobe)
      begin
        decim_count <= decim_last ? '0 : decim_count + 1'b1;
        if (!playback_q)
        begin
          if (write_enable)
            addr <= next_addr;
        end
        else if (decim_last)
        begin
          addr <= (next_addr >= record_length) ? '0 : next_addr;
        end
      end
    end
  end

  always_ff @(posedge clock)
  begin
    if (write_enable)
      last_stored <= mic_sample;
  end

  ////////////////////////////////////////////////////////////
  // output pipeline from ram read through mix to audio_out
  ////////////////////////////////////////////////////////////

  // 3/4 current plus 1/4 echo peaks at 253 and never overflows
  assign mix = (read_data >> 1) + (read_data >> 2) + (echo_data >> 2);

  always_ff @(posedge clock)
  begin
    if (strobe_d1)
      out_stage <= playback_q ? mix : last_stored;
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      strobe_d1 <= 1'b0;
      strobe_d2 <= 1'b0;
      audio_out <= '0;
    end
    else
    begin
      strobe_d1 <= sample_strobe;
      strobe_d2 <= strobe_d1;
      if (strobe_d2)
        audio_out <= out_stage;
    end
  end

endmodule

// ==== rtl/sample_ram.sv ====
`timescale 1ns/1ps

module sample_ram
  import voice_recorder_pkg::*;
(
  input  logic    clock,
  input  logic    write_enable,
  input  addr_t   write_addr,
  input  sample_t write_data,
  input  addr_t   read_addr,
  input  addr_t   echo_addr,
  output sample_t read_data,
  output sample_t echo_data
);

  sample_t mem [0:(1 << ADDR_WIDTH)-1];

  // one write port, two registered read ports
  always_ff @(posedge clock)
  begin
    if (write_enable)
      mem[write_addr] <= write_data;
    read_data <= mem[read_addr];
    echo_data <= mem[echo_addr];
  end

endmodule

// ==== rtl/codec_control.sv ====
`timescale 1ns/1ps

module codec_control
  import voice_recorder_pkg::*;
(
  input  logic           clock,
  input  logic           reset,
  input  logic           sample_strobe,
  input  volume_t        volume,
  output logic           codec_reset_b,
  output codec_command_t command
);

  logic [$clog2(CODEC_RESET_CYCLES)-1:0] reset_count;
  logic [$clog2(SEQUENCE_LENGTH)-1:0] step;
  volume_t attenuation;
  codec_command_t next_command;

  ////////////////////////////////////////////////////////////
  // codec reset delay
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      reset_count <= '0;
      codec_reset_b <= 1'b0;
    end
    else if (reset_count == CODEC_RESET_CYCLES - 1)
      codec_reset_b <= 1'b1;
    else
      reset_count <= reset_count + 1'b1;
  end

  ////////////////////////////////////////////////////////////
  // command sequence with one step per strobe
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock)
  begin
    if (reset)
      step <= '0;
    else if (codec_reset_b && sample_strobe)
      step <= (step == SEQUENCE_LENGTH - 1) ? '0 : step + 1'b1;
  end

  // the codec wants attenuation, not gain
  assign attenuation = VOLUME_MAX - volume;

  always_comb
  begin
    next_command.valid = codec_reset_b;
    case (step)
      3:
      begin
        // same attenuation on left and right
        next_command.address = REG_HEADPHONE_VOL;
        next_command.data = {3'b000, attenuation, 3'b000, attenuation};
      end
      5:
      begin
        next_command.address = REG_PCM_VOL;
        next_command.data = PCM_VOL_DATA;
      end
      6:
      begin
        next_command.address = REG_RECORD_SELECT;
        next_command.data = {5'b00000, MIC_SOURCE, 5'b00000, MIC_SOURCE};
      end
      7:
      begin
        next_command.address = REG_RECORD_GAIN;
        next_command.data = RECORD_GAIN_DATA;
      end
      9:
      begin
        next_command.address = REG_MIC_GAIN;
        next_command.data = MIC_GAIN_DATA;
      end
      10:
      begin
        next_command.address = REG_BEEP_VOL;
        next_command.data = BEEP_VOL_DATA;
      end
      11:
      begin
        next_command.address = REG_GENERAL;
        next_command.data = BYPASS_DATA;
      end
      default:
      begin
        // idle steps just read the vendor ID
        next_command.address = REG_READ_ID;
        next_command.data = '0;
      end
    endcase
  end

  always_ff @(posedge clock)
  begin
    if (reset)
      command <= '0;
    else
      command <= next_command;
  end

endmodule

// ==== rtl/volume_control.sv ====
`timescale 1ns/1ps

module volume_control
  import voice_recorder_pkg::*;
(
  input  logic    clock,
  input  logic    reset,
  input  logic    up,
  input  logic    down,
  output volume_t volume
);

  logic up_clean;
  logic down_clean;
  logic up_prev;
  logic down_prev;
  logic up_rise;
  logic down_rise;

  button_debouncer i_up_debouncer (
    .clock (clock),
    .reset (reset),
    .noisy (up),
    .clean (up_clean)
  );

  button_debouncer i_down_debouncer (
    .clock (clock),
    .reset (reset),
    .noisy (down),
    .clean (down_clean)
  );

  // one step per press on the debounced rising edge
  assign up_rise = up_clean & ~up_prev;
  assign down_rise = down_clean & ~down_prev;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      up_prev <= 1'b0;
      down_prev <= 1'b0;
      volume <= VOLUME_RESET;
    end
    else
    begin
      up_prev <= up_clean;
      down_prev <= down_clean;
      // saturate at both ends and let up win when both arrive together
      if (up_rise && volume != VOLUME_MAX)
        volume <= volume + 1'b1;
      else if (down_rise && volume != '0)
        volume <= volume - 1'b1;
    end
  end

endmodule

// ==== rtl/button_debouncer.sv ====
`timescale 1ns/1ps

module button_debouncer
  import voice_recorder_pkg::*;
(
  input  logic clock,
  input  logic reset,
  input  logic noisy,
  output logic clean
);

  // level seen on the last cycle and how long it has held
  logic held;
  logic [$clog2(DEBOUNCE_CYCLES+1)-1:0] count;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      held <= 1'b0;
      count <= '0;
      clean <= 1'b0;
    end
    else if (noisy != held)
    begin
      // restart timing when the input moves
      held <= noisy;
      count <= '0;
    end
    else if (count == DEBOUNCE_CYCLES)
    begin
      clean <= held;
    end
    else
    begin
      count <= count + 1'b1;
    end
  end

endmodule

// ==== rtl/voice_recorder_pkg.sv ====
package voice_recorder_pkg;

  ////////////////////////////////////////////////////////////
  // sample path
  ////////////////////////////////////////////////////////////

  localparam int SAMPLE_WIDTH = 8;
  typedef logic [SAMPLE_WIDTH-1:0] sample_t;

  // 1024 stored samples
  localparam int ADDR_WIDTH = 10;
  typedef logic [ADDR_WIDTH-1:0] addr_t;

  // input strobes per stored sample
  localparam int DECIMATION = 8;
  // echo tap distance, in stored samples
  localparam int ECHO_DELAY = 128;

  ////////////////////////////////////////////////////////////
  // buttons and volume
  ////////////////////////////////////////////////////////////

  localparam int DEBOUNCE_CYCLES = 20;

  typedef logic [4:0] volume_t;
  localparam volume_t VOLUME_RESET = 5'd8;
  localparam volume_t VOLUME_MAX = 5'd31;

  typedef struct packed {
    logic up;
    logic down;
    logic playback;
  } buttons_t;

  ////////////////////////////////////////////////////////////
  // codec control
  ////////////////////////////////////////////////////////////

  localparam int CODEC_RESET_CYCLES = 1024;
  localparam int SEQUENCE_LENGTH = 16;

  // bit 7 of a register address marks a read
  localparam logic [7:0] REG_READ_ID = 8'h80;
  localparam logic [7:0] REG_HEADPHONE_VOL = 8'h04;
  localparam logic [7:0] REG_PCM_VOL = 8'h18;
  localparam logic [7:0] REG_RECORD_SELECT = 8'h1A;
  localparam logic [7:0] REG_RECORD_GAIN = 8'h1C;
  localparam logic [7:0] REG_MIC_GAIN = 8'h0E;
  localparam logic [7:0] REG_BEEP_VOL = 8'h0A;
  localparam logic [7:0] REG_GENERAL = 8'h20;

  localparam logic [15:0] PCM_VOL_DATA = 16'h0808;
  // record gain at maximum
  localparam logic [15:0] RECORD_GAIN_DATA = 16'h0F0F;
  // +20 dB mic boost
  localparam logic [15:0] MIC_GAIN_DATA = 16'h8048;
  localparam logic [15:0] BEEP_VOL_DATA = 16'h0000;
  // PCM out bypasses the 3D mixer
  localparam logic [15:0] BYPASS_DATA = 16'h8000;
  localparam logic [2:0] MIC_SOURCE = 3'b000;

  typedef struct packed {
    logic        valid;
    logic [7:0]  address;
    logic [15:0] data;
  } codec_command_t;

endpackage
